// ==== build.f ====
hw/ci_pkg.sv
hw/main_memory.sv
hw/mem_arbiter.sv
hw/icache.sv
hw/dcache.sv
hw/cpu_interface.sv
sim/ci_properties.sv
sim/ci_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert
LINTFLAGS := --lint-only -Wall
TOP       := ci_tb
RTL_TOP   := cpu_interface
FILELIST  := build.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || echo "** FAIL **" >> $(LOG)
	cat $(LOG)
	@if grep -qF "** FAIL **" $(LOG); then exit 1; fi

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== sim/ci_tb.sv ====
`timescale 1ns/1ps

module ci_tb;

    logic                      clk;
    logic                      rst;
    logic [ci_pkg::ADDR_W-1:0] ic_addr;
    logic                      dc_read;
    logic                      dc_write;
    logic [ci_pkg::ADDR_W-1:0] dc_addr;
    logic [ci_pkg::DATA_W-1:0] dc_wdata;
    logic [ci_pkg::BE_W-1:0]   dc_byte_w_en;
    logic [ci_pkg::DATA_W-1:0] ic_data;
    logic [ci_pkg::DATA_W-1:0] dc_data;
    logic                      mem_stall;

    // Reference copy of main memory
    logic [ci_pkg::DATA_W-1:0] shadow [2**ci_pkg::MEM_AW];
    logic [15:0]               lfsr;
    logic                      checks_on;
    logic [ci_pkg::DATA_W-1:0] dc_exp;
    logic [ci_pkg::DATA_W-1:0] ic_exp;

    // Next operation
    ci_pkg::cache_addr_t       pick;
    logic [31:0]               bits;
    logic                      op_write;
    logic [ci_pkg::BE_W-1:0]   op_be;
    logic [ci_pkg::DATA_W-1:0] op_data;
    logic [ci_pkg::ADDR_W-1:0] op_fetch;

    cpu_interface u_dut (
        .clk          (clk),
        .rst          (rst),
        .ic_addr      (ic_addr),
        .dc_read      (dc_read),
        .dc_write     (dc_write),
        .dc_addr      (dc_addr),
        .dc_wdata     (dc_wdata),
        .dc_byte_w_en (dc_byte_w_en),
        .ic_data      (ic_data),
        .dc_data      (dc_data),
        .mem_stall    (mem_stall)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Taps 16 14 13 11, one step per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
            val  = {val[30:0], lfsr[0]};
        end
        return val;
    endfunction

    ////////////////////////////////////////
    // Operation choice
    ////////////////////////////////////////

    task automatic choose_op();
        bits = take_bits(1);
        op_write = bits[0];
        bits = take_bits(4);
        op_be = bits[3:0];
        op_data = take_bits(32);
        // Tags 0, 8, 16 all land on index 8 or 9
        pick.word = '0;
        bits = take_bits(2);
        pick.fld.tag = (bits[1:0] == 2'd2) ? 22'd16 : (bits[1:0] == 2'd0) ? 22'd0 : 22'd8;
        bits = take_bits(1);
        pick.fld.index = 6'd8 + 6'(bits[0]);
        bits = take_bits(2);
        pick.fld.offset = bits[1:0];
        // Code region, written only by the preload
        bits = take_bits(8);
        op_fetch = 30'h1800 + 30'(bits[7:0]);
    endtask

    // Present one operation and hold it through the stall
    task automatic present_op(input logic                      wr,
                              input logic [ci_pkg::ADDR_W-1:0] addr,
                              input logic [ci_pkg::DATA_W-1:0] data,
                              input logic [ci_pkg::BE_W-1:0]   be,
                              input logic [ci_pkg::ADDR_W-1:0] fetch);
        // New operation only after a stall-free cycle
        do begin
            @(negedge clk);
        end while (mem_stall);
        @(posedge clk);
        dc_read      <= !wr;
        dc_write     <= wr;
        dc_addr      <= addr;
        dc_wdata     <= data;
        dc_byte_w_en <= be;
        ic_addr      <= fetch;
        checks_on    <= 1'b1;
        // Held until a stall-free cycle
        do begin
            @(negedge clk);
        end while (mem_stall);
        // One idle cycle lets the write flag clear
        @(posedge clk);
        dc_read  <= 1'b0;
        dc_write <= 1'b0;
    endtask

    ////////////////////////////////////////
    // Checks on stall-free cycles
    ////////////////////////////////////////

    always @(negedge clk) begin
        if (checks_on && !mem_stall) begin
            if (dc_write) begin
                for (int b = 0; b < ci_pkg::BE_W; b++) begin
                    if (dc_byte_w_en[b]) begin
                        shadow[dc_addr[ci_pkg::MEM_AW-1:0]][8*b +: 8] = dc_wdata[8*b +: 8];
                    end
                end
            end
            dc_exp = shadow[dc_addr[ci_pkg::MEM_AW-1:0]];
            ic_exp = shadow[ic_addr[ci_pkg::MEM_AW-1:0]];
            if (dc_read) begin
                assert (dc_data === dc_exp) else begin
                    $display("mismatch at %0t: data read addr %h expected %h got %h",
                             $time, dc_addr, dc_exp, dc_data);
                    $display("** FAIL **");
                    $fatal(1);
                end
            end
            assert (ic_data === ic_exp) else begin
                $display("mismatch at %0t: fetch addr %h expected %h got %h",
                         $time, ic_addr, ic_exp, ic_data);
                $display("** FAIL **");
                $fatal(1);
            end
        end
    end

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////

    initial begin
        for (int i = 0; i < 2**ci_pkg::MEM_AW; i++) begin
            shadow[i] = '0;
        end
        lfsr         = 16'd69;
        rst          = 1'b1;
        checks_on    = 1'b0;
        ic_addr      = '0;
        dc_read      = 1'b0;
        dc_write     = 1'b0;
        dc_addr      = '0;
        dc_wdata     = '0;
        dc_byte_w_en = '0;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        // Code region filled through the data port before any fetch from it
        for (int i = 0; i < 256; i++) begin
            op_data = take_bits(32);
            present_op(1'b1, 30'h1800 + 30'(i), op_data, 4'hF, '0);
        end
        for (int op = 0; op < 400; op++) begin
            choose_op();
            present_op(op_write, pick.word, op_data, op_be, op_fetch);
        end
        @(negedge clk);
        $display("** PASS **");
        $finish;
    end

    // Every operation, preload included, gets two refills and a few spare cycles
    initial begin
        #((256 + 400) * (2 * (ci_pkg::MEM_LATENCY + 6) + 4) * 40);
        $display("run timed out before all operations finished");
        $display("** FAIL **");
        $fatal(1);
    end

endmodule

// ==== sim/ci_properties.sv ====
`timescale 1ns/1ps

module ci_properties (
    input logic clk,
    input logic rst,
    input logic mem_stall,
    input logic ic_mem_req,
    input logic ic_mem_gnt,
    input logic ic_mem_done,
    input logic dc_mem_req,
    input logic dc_mem_gnt,
    input logic dc_mem_done
);

    ////////////////////////////////////////
    // Helper state
    ////////////////////////////////////////

    // Reset seen on the previous edge
    logic       rst_q;
    // Length of the current stall
    logic [7:0] stall_len;

    always_ff @(posedge clk) begin
        rst_q <= rst;
        if (rst || !mem_stall) begin
            stall_len <= '0;
        end else begin
            stall_len <= stall_len + 1'b1;
        end
    end

    ////////////////////////////////////////
    // Protocol checks
    ////////////////////////////////////////

    // Quiet during reset and right after it
    a_reset_quiet: assert property (@(posedge clk) rst |-> !mem_stall)
        else $error("stall raised during reset");
    a_first_cycle: assert property (@(posedge clk) (rst_q && !rst) |-> !mem_stall)
        else $error("stall raised on the first cycle after reset");

    // Worst case is one refill behind another
    a_stall_bound: assert property (@(posedge clk) disable iff (rst)
        stall_len <= 8'(2 * (ci_pkg::MEM_LATENCY + 6)))
        else $error("stall longer than two refills");

    // Owner keeps the port until its done
    a_ic_gnt_held: assert property (@(posedge clk) disable iff (rst)
        (ic_mem_gnt && !ic_mem_done) |=> ic_mem_gnt)
        else $error("fetch grant dropped before done");
    a_dc_gnt_held: assert property (@(posedge clk) disable iff (rst)
        (dc_mem_gnt && !dc_mem_done) |=> dc_mem_gnt)
        else $error("data grant dropped before done");

    // Requests held as levels until done
    a_ic_req_held: assert property (@(posedge clk) disable iff (rst)
        (ic_mem_req && !ic_mem_done) |=> ic_mem_req)
        else $error("fetch request dropped before done");
    a_dc_req_held: assert property (@(posedge clk) disable iff (rst)
        (dc_mem_req && !dc_mem_done) |=> dc_mem_req)
        else $error("data request dropped before done");

endmodule

bind cpu_interface ci_properties u_props (
    .clk         (clk),
    .rst         (rst),
    .mem_stall   (mem_stall),
    .ic_mem_req  (ic_mem_req),
    .ic_mem_gnt  (ic_mem_gnt),
    .ic_mem_done (ic_mem_done),
    .dc_mem_req  (dc_mem_req),
    .dc_mem_gnt  (dc_mem_gnt),
    .dc_mem_done (dc_mem_done)
);

// ==== hw/cpu_interface.sv ====
`timescale 1ns/1ps

module cpu_interface (
    input  logic                      clk,
    input  logic                      rst,
    input  logic [ci_pkg::ADDR_W-1:0] ic_addr,
    input  logic                      dc_read,
    input  logic                      dc_write,
    input  logic [ci_pkg::ADDR_W-1:0] dc_addr,
    input  logic [ci_pkg::DATA_W-1:0] dc_wdata,
    input  logic [ci_pkg::BE_W-1:0]   dc_byte_w_en,
    output logic [ci_pkg::DATA_W-1:0] ic_data,
    output logic [ci_pkg::DATA_W-1:0] dc_data,
    output logic                      mem_stall
);

    // Instruction cache to arbiter
    logic                      ic_busy;
    logic                      ic_mem_req;
    logic [ci_pkg::ADDR_W-1:0] ic_mem_addr;
    logic                      ic_mem_gnt;
    logic                      ic_mem_rvalid;
    logic [ci_pkg::DATA_W-1:0] ic_mem_rdata;
    logic                      ic_mem_done;

    // Data cache to arbiter
    logic                      dc_busy;
    logic                      dc_mem_req;
    logic                      dc_mem_we;
    logic [ci_pkg::ADDR_W-1:0] dc_mem_addr;
    logic [ci_pkg::DATA_W-1:0] dc_mem_wdata;
    logic [ci_pkg::BE_W-1:0]   dc_mem_be;
    logic                      dc_mem_gnt;
    logic                      dc_mem_rvalid;
    logic [ci_pkg::DATA_W-1:0] dc_mem_rdata;
    logic                      dc_mem_done;

    // Arbiter to main memory
    logic                      m_req;
    logic                      m_we;
    logic [ci_pkg::ADDR_W-1:0] m_addr;
    logic [ci_pkg::DATA_W-1:0] m_wdata;
    logic [ci_pkg::BE_W-1:0]   m_be;
    logic                      m_rvalid;
    logic [ci_pkg::DATA_W-1:0] m_rdata;
    logic                      m_done;

    // CPU holds everything while either cache works
    assign mem_stall = ic_busy | dc_busy;

    icache u_icache (
        .clk        (clk),
        .rst        (rst),
        .addr       (ic_addr),
        .data       (ic_data),
        .busy       (ic_busy),
        .mem_req    (ic_mem_req),
        .mem_addr   (ic_mem_addr),
        .mem_gnt    (ic_mem_gnt),
        .mem_rvalid (ic_mem_rvalid),
        .mem_rdata  (ic_mem_rdata),
        .mem_done   (ic_mem_done)
    );

    dcache u_dcache (
        .clk        (clk),
        .rst        (rst),
        .read       (dc_read),
        .write      (dc_write),
        .addr       (dc_addr),
        .wdata      (dc_wdata),
        .be         (dc_byte_w_en),
        .rdata      (dc_data),
        .busy       (dc_busy),
        .mem_req    (dc_mem_req),
        .mem_we     (dc_mem_we),
        .mem_addr   (dc_mem_addr),
        .mem_wdata  (dc_mem_wdata),
        .mem_be     (dc_mem_be),
        .mem_gnt    (dc_mem_gnt),
        .mem_rvalid (dc_mem_rvalid),
        .mem_rdata  (dc_mem_rdata),
        .mem_done   (dc_mem_done)
    );

    mem_arbiter u_arb (
        .clk      (clk),
        .rst      (rst),
        .d_req    (dc_mem_req),
        .d_we     (dc_mem_we),
        .d_addr   (dc_mem_addr),
        .d_wdata  (dc_mem_wdata),
        .d_be     (dc_mem_be),
        .d_gnt    (dc_mem_gnt),
        .d_rvalid (dc_mem_rvalid),
        .d_rdata  (dc_mem_rdata),
        .d_done   (dc_mem_done),
        .i_req    (ic_mem_req),
        .i_addr   (ic_mem_addr),
        .i_gnt    (ic_mem_gnt),
        .i_rvalid (ic_mem_rvalid),
        .i_rdata  (ic_mem_rdata),
        .i_done   (ic_mem_done),
        .m_req    (m_req),
        .m_we     (m_we),
        .m_addr   (m_addr),
        .m_wdata  (m_wdata),
        .m_be     (m_be),
        .m_rvalid (m_rvalid),
        .m_rdata  (m_rdata),
        .m_done   (m_done)
    );

    main_memory u_mem (
        .clk    (clk),
        .rst    (rst),
        .req    (m_req),
        .we     (m_we),
        .addr   (m_addr),
        .wdata  (m_wdata),
        .be     (m_be),
        .rvalid (m_rvalid),
        .rdata  (m_rdata),
        .done   (m_done)
    );

endmodule

// ==== hw/dcache.sv ====
`timescale 1ns/1ps

module dcache (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      read,
    input  logic                      write,
    input  logic [ci_pkg::ADDR_W-1:0] addr,
    input  logic [ci_pkg::DATA_W-1:0] wdata,
    input  logic [ci_pkg::BE_W-1:0]   be,
    output logic [ci_pkg::DATA_W-1:0] rdata,
    output logic                      busy,
    output logic                      mem_req,
    output logic                      mem_we,
    output logic [ci_pkg::ADDR_W-1:0] mem_addr,
    output logic [ci_pkg::DATA_W-1:0] mem_wdata,
    output logic [ci_pkg::BE_W-1:0]   mem_be,
    input  logic                      mem_gnt,
    input  logic                      mem_rvalid,
    input  logic [ci_pkg::DATA_W-1:0] mem_rdata,
    input  logic                      mem_done
);

    ////////////////////////////////////////
    // Storage
    ////////////////////////////////////////

    logic [ci_pkg::DATA_W-1:0] data_mem [ci_pkg::LINES*ci_pkg::LINE_WORDS];
    logic [ci_pkg::TAG_W-1:0]  tag_mem  [ci_pkg::LINES];
    logic [ci_pkg::LINES-1:0]  valid;

    ci_pkg::cache_addr_t         a;
    logic                        wait_gnt;
    logic                        fill;
    logic                        wr_busy;
    logic                        wr_done;
    logic [ci_pkg::OFFSET_W-1:0] fill_cnt;
    logic                        idle;
    logic                        hit;
    logic                        rd_miss;
    logic                        wr_start;

    assign a.word = addr;

    ////////////////////////////////////////
    // Lookup and request
    ////////////////////////////////////////

    assign idle = !wait_gnt && !fill && !wr_busy;
    assign hit  = valid[a.fld.index] && (tag_mem[a.fld.index] == a.fld.tag);

    assign rd_miss  = read && !hit && idle;
    // Held write goes out once per assertion of write
    assign wr_start = write && !wr_done && idle;
    assign busy     = rd_miss || wr_start || !idle;

    assign rdata = data_mem[{a.fld.index, a.fld.offset}];

    // Word address for writes, line base for refills
    assign mem_req   = !idle;
    assign mem_we    = wr_busy;
    assign mem_addr  = wr_busy ? addr
                               : {a.fld.tag, a.fld.index, {ci_pkg::OFFSET_W{1'b0}}};
    assign mem_wdata = wdata;
    assign mem_be    = be;

    ////////////////////////////////////////
    // Control
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            wait_gnt <= 1'b0;
            fill     <= 1'b0;
            wr_busy  <= 1'b0;
            wr_done  <= 1'b0;
            fill_cnt <= '0;
            valid    <= '0;
        end else begin
            // Read miss, same refill as the fetch side
            if (rd_miss) begin
                wait_gnt           <= 1'b1;
                valid[a.fld.index] <= 1'b0;
            end
            if (wait_gnt && mem_gnt) begin
                wait_gnt <= 1'b0;
                fill     <= 1'b1;
                fill_cnt <= '0;
            end
            if (fill && mem_rvalid) begin
                fill_cnt <= fill_cnt + 1'b1;
            end
            if (fill && mem_done) begin
                fill               <= 1'b0;
                valid[a.fld.index] <= 1'b1;
            end

            // Write through, no allocate on miss
            if (wr_start) begin
                wr_busy <= 1'b1;
            end
            if (wr_busy && mem_done) begin
                wr_busy <= 1'b0;
            end

            // Completed write stays marked until the CPU drops it
            if (!write) begin
                wr_done <= 1'b0;
            end else if (wr_busy && mem_done) begin
                wr_done <= 1'b1;
            end
        end
    end

    ////////////////////////////////////////
    // Array updates
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (fill && mem_rvalid) begin
            data_mem[{a.fld.index, fill_cnt}] <= mem_rdata;
        end
        if (fill && mem_done) begin
            tag_mem[a.fld.index] <= a.fld.tag;
        end
        // Merge selected bytes into a resident line
        if (wr_busy && mem_done && hit) begin
            for (int b = 0; b < ci_pkg::BE_W; b++) begin
                if (be[b]) begin
                    data_mem[{a.fld.index, a.fld.offset}][8*b +: 8] <= wdata[8*b +: 8];
                end
            end
        end
    end

endmodule

// ==== hw/icache.sv ====
`timescale 1ns/1ps

module icache (
    input  logic                      clk,
    input  logic                      rst,
    input  logic [ci_pkg::ADDR_W-1:0] addr,
    output logic [ci_pkg::DATA_W-1:0] data,
    output logic                      busy,
    output logic                      mem_req,
    output logic [ci_pkg::ADDR_W-1:0] mem_addr,
    input  logic                      mem_gnt,
    input  logic                      mem_rvalid,
    input  logic [ci_pkg::DATA_W-1:0] mem_rdata,
    input  logic                      mem_done
);

    ////////////////////////////////////////
    // Storage
    ////////////////////////////////////////

    logic [ci_pkg::DATA_W-1:0] data_mem [ci_pkg::LINES*ci_pkg::LINE_WORDS];
    logic [ci_pkg::TAG_W-1:0]  tag_mem  [ci_pkg::LINES];
    logic [ci_pkg::LINES-1:0]  valid;

    ci_pkg::cache_addr_t         a;
    logic                        wait_gnt;
    logic                        fill;
    logic                        lookup_en;
    logic [ci_pkg::OFFSET_W-1:0] fill_cnt;
    logic                        hit;
    logic                        miss;

    assign a.word = addr;

    ////////////////////////////////////////
    // Lookup
    ////////////////////////////////////////

    assign hit  = valid[a.fld.index] && (tag_mem[a.fld.index] == a.fld.tag);
    // Fetch port is live from the second cycle out of reset
    assign miss = lookup_en && !hit && !wait_gnt && !fill;
    assign busy = miss || wait_gnt || fill;

    // Hit data straight from the array
    assign data = data_mem[{a.fld.index, a.fld.offset}];

    // Line base of the held fetch address
    assign mem_req  = wait_gnt || fill;
    assign mem_addr = {a.fld.tag, a.fld.index, {ci_pkg::OFFSET_W{1'b0}}};

    ////////////////////////////////////////
    // Refill sequence
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            wait_gnt  <= 1'b0;
            fill      <= 1'b0;
            lookup_en <= 1'b0;
            fill_cnt  <= '0;
            valid     <= '0;
        end else begin
            lookup_en <= 1'b1;
            // Old line is dropped as soon as the refill starts
            if (miss) begin
                wait_gnt           <= 1'b1;
                valid[a.fld.index] <= 1'b0;
            end
            if (wait_gnt && mem_gnt) begin
                wait_gnt <= 1'b0;
                fill     <= 1'b1;
                fill_cnt <= '0;
            end
            if (fill && mem_rvalid) begin
                fill_cnt <= fill_cnt + 1'b1;
            end
            // Last word arrives with done
            if (fill && mem_done) begin
                fill               <= 1'b0;
                valid[a.fld.index] <= 1'b1;
            end
        end
    end

    // Words land in offset order
    always_ff @(posedge clk) begin
        if (fill && mem_rvalid) begin
            data_mem[{a.fld.index, fill_cnt}] <= mem_rdata;
        end
        if (fill && mem_done) begin
            tag_mem[a.fld.index] <= a.fld.tag;
        end
    end

endmodule

// ==== hw/mem_arbiter.sv ====
`timescale 1ns/1ps

module mem_arbiter (
    input  logic                      clk,
    input  logic                      rst,
    // Data cache
    input  logic                      d_req,
    input  logic                      d_we,
    input  logic [ci_pkg::ADDR_W-1:0] d_addr,
    input  logic [ci_pkg::DATA_W-1:0] d_wdata,
    input  logic [ci_pkg::BE_W-1:0]   d_be,
    output logic                      d_gnt,
    output logic                      d_rvalid,
    output logic [ci_pkg::DATA_W-1:0] d_rdata,
    output logic                      d_done,
    // Instruction cache
    input  logic                      i_req,
    input  logic [ci_pkg::ADDR_W-1:0] i_addr,
    output logic                      i_gnt,
    output logic                      i_rvalid,
    output logic [ci_pkg::DATA_W-1:0] i_rdata,
    output logic                      i_done,
    // Main memory
    output logic                      m_req,
    output logic                      m_we,
    output logic [ci_pkg::ADDR_W-1:0] m_addr,
    output logic [ci_pkg::DATA_W-1:0] m_wdata,
    output logic [ci_pkg::BE_W-1:0]   m_be,
    input  logic                      m_rvalid,
    input  logic [ci_pkg::DATA_W-1:0] m_rdata,
    input  logic                      m_done
);

    // High while the data cache owns the port
    logic owner_d;
    logic busy;

    // Grant only from idle, held until done
    always_ff @(posedge clk) begin
        if (rst) begin
            busy    <= 1'b0;
            owner_d <= 1'b0;
        end else if (!busy) begin
            if (d_req) begin
                busy    <= 1'b1;
                owner_d <= 1'b1;
            end else if (i_req) begin
                busy    <= 1'b1;
                owner_d <= 1'b0;
            end
        end else if (m_done) begin
            busy <= 1'b0;
        end
    end

    assign d_gnt = busy && owner_d;
    assign i_gnt = busy && !owner_d;

    // Owner's request to memory
    assign m_req   = owner_d ? d_gnt && d_req : i_gnt && i_req;
    assign m_we    = d_gnt && d_we;
    assign m_addr  = owner_d ? d_addr : i_addr;
    assign m_wdata = d_wdata;
    assign m_be    = d_be;

    // Return strobes to the owner only
    assign d_rvalid = d_gnt && m_rvalid;
    assign d_done   = d_gnt && m_done;
    assign d_rdata  = m_rdata;
    assign i_rvalid = i_gnt && m_rvalid;
    assign i_done   = i_gnt && m_done;
    assign i_rdata  = m_rdata;

endmodule

// ==== hw/main_memory.sv ====
`timescale 1ns/1ps

module main_memory (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      req,
    input  logic                      we,
    input  logic [ci_pkg::ADDR_W-1:0] addr,
    input  logic [ci_pkg::DATA_W-1:0] wdata,
    input  logic [ci_pkg::BE_W-1:0]   be,
    output logic                      rvalid,
    output logic [ci_pkg::DATA_W-1:0] rdata,
    output logic                      done
);

    logic [ci_pkg::DATA_W-1:0] mem [2**ci_pkg::MEM_AW];

    // Captured request
    logic                      we_q;
    logic [ci_pkg::MEM_AW-1:0] addr_q;
    logic [ci_pkg::DATA_W-1:0] wdata_q;
    logic [ci_pkg::BE_W-1:0]   be_q;

    logic                                  active;
    logic [$clog2(ci_pkg::MEM_LATENCY)-1:0] cnt;
    logic [ci_pkg::OFFSET_W-1:0]           beat;
    logic                                  lat_done;

    initial begin
        for (int i = 0; i < 2**ci_pkg::MEM_AW; i++) begin
            mem[i] = '0;
        end
    end

    ////////////////////////////////////////
    // Latency and burst sequencing
    ////////////////////////////////////////

    // Last latency cycle carries the first word or the write ack
    assign lat_done = active && (cnt == ci_pkg::MEM_LATENCY - 1);

    assign rvalid = lat_done && !we_q;
    assign rdata  = mem[{addr_q[ci_pkg::MEM_AW-1:ci_pkg::OFFSET_W], beat}];
    assign done   = lat_done && (we_q || (&beat));

    always_ff @(posedge clk) begin
        if (rst) begin
            active <= 1'b0;
            cnt    <= '0;
            beat   <= '0;
        end else if (!active) begin
            if (req) begin
                active <= 1'b1;
                cnt    <= '0;
                beat   <= '0;
            end
        end else begin
            if (!lat_done) begin
                cnt <= cnt + 1'b1;
            end else if (!we_q) begin
                beat <= beat + 1'b1;
            end
            if (done) begin
                active <= 1'b0;
            end
        end
    end

    // Upper address bits fall outside the array
    always_ff @(posedge clk) begin
        if (!active && req) begin
            we_q    <= we;
            addr_q  <= addr[ci_pkg::MEM_AW-1:0];
            wdata_q <= wdata;
            be_q    <= be;
        end
    end

    ////////////////////////////////////////
    // Byte-masked write
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (lat_done && we_q) begin
            for (int b = 0; b < ci_pkg::BE_W; b++) begin
                if (be_q[b]) begin
                    mem[addr_q][8*b +: 8] <= wdata_q[8*b +: 8];
                end
            end
        end
    end

endmodule

// ==== hw/ci_pkg.sv ====
package ci_pkg;

    ////////////////////////////////////////
    // Address and data geometry
    ////////////////////////////////////////

    // Word address, word data, byte lanes
    localparam int ADDR_W = 30;
    localparam int DATA_W = 32;
    localparam int BE_W   = 4;

    // Direct-mapped line layout
    localparam int OFFSET_W   = 2;
    localparam int LINE_WORDS = 4;
    localparam int INDEX_W    = 6;
    localparam int LINES      = 64;
    localparam int TAG_W      = ADDR_W - INDEX_W - OFFSET_W;

    ////////////////////////////////////////
    // Main memory model
    ////////////////////////////////////////

    // 8192 words behind the arbiter
    localparam int MEM_AW = 13;
    // Request accept to first word or write ack
    localparam int MEM_LATENCY = 8;

    // Same 30 bits, seen flat or split for lookup
    typedef union packed {
        logic [ADDR_W-1:0] word;
        struct packed {
            logic [TAG_W-1:0]    tag;
            logic [INDEX_W-1:0]  index;
            logic [OFFSET_W-1:0] offset;
        } fld;
    } cache_addr_t;

endpackage
